// ==== src/rms_norm_defines.svh ====
// RMS norm front end parameters
`ifndef RMS_NORM_DEFINES_SVH
`define RMS_NORM_DEFINES_SVH

// Lane and input format
`define BUS_NUM          4
`define DATA_WIDTH       8

// bfloat16 format
`define SIG_WIDTH        7
`define EXP_WIDTH        8
`define FLOAT_WIDTH      16
`define EXP_BIAS         127

// Vector configuration
`define DATA_NUM_WIDTH   10
`define SCALE_POS_WIDTH  5
`define SQUARE_SUM_WIDTH 24

// Row buffers and replay timing
`define BUF_DEPTH        32
`define BUF_PTR_WIDTH    5
`define REPLAY_LATENCY   2

`endif

// ==== src/rms_norm_pkg.sv ====
// RMS norm shared types
`include "rms_norm_defines.svh"

package rms_norm_pkg;

  // One bfloat16 word, sign above exponent above fraction
  typedef struct packed {
    logic                  sign;
    logic [`EXP_WIDTH-1:0] exp;
    logic [`SIG_WIDTH-1:0] frac;
  } bf16_t;

  // One strobe per input lane
  typedef logic [`BUS_NUM-1:0] lane_vld_t;

  // Control phases of one vector
  typedef enum logic [1:0] {
    PH_COLLECT,
    PH_SUM,
    PH_REPLAY
  } phase_e;

endpackage

// ==== src/int_to_bf16.sv ====
// Integer to bfloat16 converter
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module int_to_bf16 #(
  parameter int ISIZE = 8
) (
  input  logic signed [ISIZE-1:0]   value,
  output logic [`FLOAT_WIDTH-1:0]   z
);

  localparam int POS_WIDTH = $clog2(ISIZE);
  localparam logic [`EXP_WIDTH-1:0] BIAS = `EXP_BIAS;

  logic                   sign;
  logic [ISIZE-1:0]       mag;
  logic [POS_WIDTH-1:0]   lead_pos;
  logic [ISIZE-1:0]       norm;
  logic [`EXP_WIDTH-1:0]  exp_field;
  logic [`SIG_WIDTH-1:0]  frac_field;

  assign sign = value[ISIZE-1];
  // Two's complement magnitude, the most negative value stays correct as unsigned
  assign mag  = sign ? (~value + 1'b1) : value;

  // Leading one search, the highest set bit wins
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < ISIZE; i++) begin
      if (mag[i]) begin
        lead_pos = POS_WIDTH'(i);
      end
    end
  end

  // Move the leading one to the top bit, fraction sits right below it
  assign norm       = mag << (POS_WIDTH'(ISIZE - 1) - lead_pos);
  assign frac_field = norm[ISIZE-2 -: `SIG_WIDTH];
  assign exp_field  = BIAS + {{(`EXP_WIDTH-POS_WIDTH){1'b0}}, lead_pos};

  assign z = (mag == '0) ? '0 : {sign, exp_field, frac_field};

endmodule

// ==== src/bf16_mult.sv ====
// Truncating bfloat16 multiplier
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module bf16_mult import rms_norm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  bf16_t a,
  input  bf16_t b,
  input  logic  in_vld,
  output bf16_t z,
  output logic  z_vld
);

  localparam logic [`EXP_WIDTH+1:0] BIAS = `EXP_BIAS;

  logic                     a_zero;
  logic                     b_zero;
  logic [`SIG_WIDTH:0]      a_mant;
  logic [`SIG_WIDTH:0]      b_mant;
  logic [2*`SIG_WIDTH+1:0]  prod;
  logic [`EXP_WIDTH+1:0]    exp_sum;
  bf16_t                    prod_bf;

  assign a_zero = ({a.exp, a.frac} == '0);
  assign b_zero = ({b.exp, b.frac} == '0);

  // Mantissas with the hidden one restored
  assign a_mant = {1'b1, a.frac};
  assign b_mant = {1'b1, b.frac};
  assign prod   = a_mant * b_mant;

  // Two extra bits keep the bias subtraction clear of wrap in the middle
  assign exp_sum = {2'b00, a.exp} + {2'b00, b.exp} - BIAS;

  always_comb begin
    prod_bf.sign = a.sign ^ b.sign;
    if (prod[2*`SIG_WIDTH+1]) begin
      // Product in [2,4), renormalize by one
      prod_bf.exp  = exp_sum[`EXP_WIDTH-1:0] + 1'b1;
      prod_bf.frac = prod[2*`SIG_WIDTH -: `SIG_WIDTH];
    end else begin
      prod_bf.exp  = exp_sum[`EXP_WIDTH-1:0];
      prod_bf.frac = prod[2*`SIG_WIDTH-1 -: `SIG_WIDTH];
    end
    if (a_zero || b_zero) begin
      prod_bf = '0;
    end
  end

  // ----------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    z <= prod_bf;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      z_vld <= 1'b0;
    end else begin
      z_vld <= in_vld;
    end
  end

endmodule

// ==== src/square_sum_acc.sv ====
// Square sum accumulator
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module square_sum_acc import rms_norm_pkg::*; (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`DATA_NUM_WIDTH-1:0]             in_k,
  input  logic                                   in_k_vld,
  input  logic [`BUS_NUM-1:0][`DATA_WIDTH-1:0]   in_fixed_data,
  input  lane_vld_t                              in_fixed_data_vld,
  input  logic signed [`SCALE_POS_WIDTH-1:0]     scale_pos,
  input  logic                                   vector_done,
  output bf16_t                                  sum_float,
  output logic                                   sum_float_vld
);

  logic [`DATA_NUM_WIDTH-1:0]    k_reg;
  logic [2*`DATA_WIDTH-1:0]      sq [`BUS_NUM];
  lane_vld_t                     sq_vld;
  logic [`DATA_NUM_WIDTH-1:0]    sq_cnt;
  logic [`DATA_NUM_WIDTH-1:0]    nxt_cnt;
  logic [`SQUARE_SUM_WIDTH-1:0]  sq_sum;
  logic [`SQUARE_SUM_WIDTH-1:0]  nxt_sum;
  logic                          sum_done;
  logic                          sum_hit;
  bf16_t                         sum_raw;
  logic [`EXP_WIDTH-1:0]         scale_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      k_reg <= '0;
    end else if (in_k_vld) begin
      k_reg <= in_k;
    end
  end

  // ----------------------------------------------------------
  // Per-lane squares, silenced once the sum is out
  // ----------------------------------------------------------
  for (genvar i = 0; i < `BUS_NUM; i++) begin : g_square
    always_ff @(posedge clk) begin
      if (sum_done) begin
        sq[i] <= '0;
      end else begin
        sq[i] <= $signed(in_fixed_data[i]) * $signed(in_fixed_data[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_vld <= '0;
    end else begin
      sq_vld <= sum_done ? '0 : in_fixed_data_vld;
    end
  end

  // ----------------------------------------------------------
  // Lane 0 first, stop adding as soon as K elements are in
  // ----------------------------------------------------------
  always_comb begin
    nxt_cnt = sq_cnt;
    nxt_sum = sq_sum;
    for (int i = 0; i < `BUS_NUM; i++) begin
      if (sq_vld[i] && (nxt_cnt < k_reg)) begin
        nxt_cnt = nxt_cnt + 1'b1;
        nxt_sum = nxt_sum + {{(`SQUARE_SUM_WIDTH-2*`DATA_WIDTH){1'b0}}, sq[i]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_cnt <= '0;
      sq_sum <= '0;
    end else if (vector_done) begin
      sq_cnt <= '0;
      sq_sum <= '0;
    end else begin
      sq_cnt <= nxt_cnt;
      sq_sum <= nxt_sum;
    end
  end

  // First cycle with the count at a nonzero K
  assign sum_hit = (sq_cnt == k_reg) && (k_reg != '0) && !sum_done;

  // ----------------------------------------------------------
  // Float result with input scale removed
  // ----------------------------------------------------------
  int_to_bf16 #(
    .ISIZE (`SQUARE_SUM_WIDTH)
  ) u_sum_conv (
    .value (sq_sum),
    .z     (sum_raw)
  );

  assign scale_ext = {{(`EXP_WIDTH-`SCALE_POS_WIDTH){scale_pos[`SCALE_POS_WIDTH-1]}}, scale_pos};

  always_ff @(posedge clk) begin
    if (sum_hit) begin
      sum_float <= (sum_raw == '0) ? '0 : {sum_raw.sign, sum_raw.exp - scale_ext, sum_raw.frac};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_done      <= 1'b0;
      sum_float_vld <= 1'b0;
    end else if (vector_done) begin
      sum_done      <= 1'b0;
      sum_float_vld <= 1'b0;
    end else begin
      sum_float_vld <= sum_hit;
      if (sum_hit) begin
        sum_done <= 1'b1;
      end
    end
  end

endmodule

// ==== src/vector_buffer.sv ====
// Data and gamma row buffers
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module vector_buffer import rms_norm_pkg::*; (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`BUS_NUM-1:0][`DATA_WIDTH-1:0]   in_fixed_data,
  input  lane_vld_t                              in_fixed_data_vld,
  input  bf16_t [`BUS_NUM-1:0]                   in_gamma,
  input  lane_vld_t                              in_gamma_vld,
  input  logic signed [`SCALE_POS_WIDTH-1:0]     scale_pos,
  input  logic                                   rd_en,
  input  logic                                   vector_done,
  output bf16_t [`BUS_NUM-1:0]                   x_row,
  output bf16_t [`BUS_NUM-1:0]                   gamma_row,
  output lane_vld_t                              row_vld
);

  bf16_t [`BUS_NUM-1:0]        conv_raw;
  bf16_t [`BUS_NUM-1:0]        conv_row;
  lane_vld_t                   conv_vld;
  bf16_t [`BUS_NUM-1:0]        data_mem  [`BUF_DEPTH];
  lane_vld_t                   vld_mem   [`BUF_DEPTH];
  bf16_t [`BUS_NUM-1:0]        gamma_mem [`BUF_DEPTH];
  logic [`BUF_PTR_WIDTH-1:0]   data_wr_ptr;
  logic [`BUF_PTR_WIDTH-1:0]   gamma_wr_ptr;
  logic [`BUF_PTR_WIDTH-1:0]   rd_ptr;
  lane_vld_t                   vld_row;
  logic                        rd_en_d;
  logic [`EXP_WIDTH-1:0]       scale_ext;

  assign scale_ext = {{(`EXP_WIDTH-`SCALE_POS_WIDTH){scale_pos[`SCALE_POS_WIDTH-1]}}, scale_pos};

  // ----------------------------------------------------------
  // Input conversion, one cycle
  // ----------------------------------------------------------
  for (genvar i = 0; i < `BUS_NUM; i++) begin : g_conv
    int_to_bf16 #(
      .ISIZE (`DATA_WIDTH)
    ) u_conv (
      .value (in_fixed_data[i]),
      .z     (conv_raw[i])
    );

    // Zero keeps a zero exponent, everything else gets the scale removed
    always_ff @(posedge clk) begin
      if (conv_raw[i] == '0) begin
        conv_row[i] <= '0;
      end else begin
        conv_row[i] <= {conv_raw[i].sign, conv_raw[i].exp - scale_ext, conv_raw[i].frac};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conv_vld <= '0;
    end else begin
      conv_vld <= in_fixed_data_vld;
    end
  end

  // ----------------------------------------------------------
  // Row storage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (|conv_vld) begin
      data_mem[data_wr_ptr] <= conv_row;
      vld_mem[data_wr_ptr]  <= conv_vld;
    end
    if (|in_gamma_vld) begin
      gamma_mem[gamma_wr_ptr] <= in_gamma;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_wr_ptr  <= '0;
      gamma_wr_ptr <= '0;
    end else if (vector_done) begin
      data_wr_ptr  <= '0;
      gamma_wr_ptr <= '0;
    end else begin
      if (|conv_vld) begin
        data_wr_ptr <= data_wr_ptr + 1'b1;
      end
      if (|in_gamma_vld) begin
        gamma_wr_ptr <= gamma_wr_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Replay, both buffers share one read pointer
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rd_en) begin
      x_row     <= data_mem[rd_ptr];
      gamma_row <= gamma_mem[rd_ptr];
      vld_row   <= vld_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      rd_en_d <= 1'b0;
    end else begin
      rd_en_d <= rd_en;
      if (vector_done) begin
        rd_ptr <= '0;
      end else if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign row_vld = vld_row & {`BUS_NUM{rd_en_d}};

endmodule

// ==== src/rms_norm_ctrl.sv ====
// RMS norm control
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module rms_norm_ctrl import rms_norm_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [`DATA_NUM_WIDTH-1:0]          in_data_num,
  input  logic                                in_data_num_vld,
  input  logic signed [`SCALE_POS_WIDTH-1:0]  in_scale_pos,
  input  logic                                in_scale_pos_vld,
  input  logic                                sum_float_vld,
  output logic signed [`SCALE_POS_WIDTH-1:0]  scale_pos,
  output logic                                rd_en,
  output logic                                vector_done
);

  localparam int LANE_SHIFT = $clog2(`BUS_NUM);
  localparam logic [`DATA_NUM_WIDTH:0] ROUND_UP = `BUS_NUM - 1;

  logic [`DATA_NUM_WIDTH-1:0]  data_num;
  logic [`DATA_NUM_WIDTH:0]    row_total;
  logic [`DATA_NUM_WIDTH:0]    row_cnt;
  logic                        start_replay;
  logic                        last_issue;
  logic [`REPLAY_LATENCY-1:0]  last_pipe;
  phase_e                      phase;

  // ----------------------------------------------------------
  // Configuration registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_num  <= '0;
      scale_pos <= '0;
    end else begin
      if (in_data_num_vld) begin
        data_num <= in_data_num;
      end
      if (in_scale_pos_vld) begin
        scale_pos <= in_scale_pos;
      end
    end
  end

  // Rows per vector, partial last row included
  assign row_total = ({1'b0, data_num} + ROUND_UP) >> LANE_SHIFT;

  assign start_replay = sum_float_vld && (phase != PH_REPLAY) && (row_total != '0);
  assign last_issue   = rd_en && (row_cnt == row_total - 1'b1);

  // ----------------------------------------------------------
  // Phase machine
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= PH_COLLECT;
    end else if (vector_done) begin
      phase <= PH_COLLECT;
    end else if (start_replay) begin
      // A vector that reuses the old configuration skips PH_SUM
      phase <= PH_REPLAY;
    end else if ((phase == PH_COLLECT) && (in_data_num_vld || in_scale_pos_vld)) begin
      phase <= PH_SUM;
    end
  end

  // Row issue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en   <= 1'b0;
      row_cnt <= '0;
    end else if (vector_done) begin
      rd_en   <= 1'b0;
      row_cnt <= '0;
    end else if (start_replay) begin
      rd_en   <= 1'b1;
      row_cnt <= '0;
    end else if (rd_en) begin
      row_cnt <= row_cnt + 1'b1;
      if (last_issue) begin
        rd_en <= 1'b0;
      end
    end
  end

  // Final-row marker follows the buffer and multiplier stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_pipe <= '0;
    end else begin
      last_pipe <= {last_pipe[`REPLAY_LATENCY-2:0], last_issue};
    end
  end

  assign vector_done = last_pipe[`REPLAY_LATENCY-1];

endmodule

// ==== src/rms_norm_top.sv ====
// RMS norm front end top
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module rms_norm_top import rms_norm_pkg::*; (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [`DATA_NUM_WIDTH-1:0]             in_data_num,
  input  logic                                   in_data_num_vld,
  input  logic [`DATA_NUM_WIDTH-1:0]             in_k,
  input  logic                                   in_k_vld,
  input  logic signed [`SCALE_POS_WIDTH-1:0]     in_scale_pos,
  input  logic                                   in_scale_pos_vld,
  input  logic [`BUS_NUM-1:0][`DATA_WIDTH-1:0]   in_fixed_data,
  input  lane_vld_t                              in_fixed_data_vld,
  input  bf16_t [`BUS_NUM-1:0]                   in_gamma,
  input  lane_vld_t                              in_gamma_vld,
  output bf16_t                                  out_sum_float,
  output logic                                   out_sum_float_vld,
  output bf16_t [`BUS_NUM-1:0]                   out_data,
  output lane_vld_t                              out_data_vld,
  output logic                                   out_data_last
);

  logic signed [`SCALE_POS_WIDTH-1:0]  scale_pos;
  logic                                rd_en;
  logic                                vector_done;
  bf16_t [`BUS_NUM-1:0]                x_row;
  bf16_t [`BUS_NUM-1:0]                gamma_row;
  lane_vld_t                           row_vld;

  rms_norm_ctrl u_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_data_num      (in_data_num),
    .in_data_num_vld  (in_data_num_vld),
    .in_scale_pos     (in_scale_pos),
    .in_scale_pos_vld (in_scale_pos_vld),
    .sum_float_vld    (out_sum_float_vld),
    .scale_pos        (scale_pos),
    .rd_en            (rd_en),
    .vector_done      (vector_done)
  );

  square_sum_acc u_acc (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_k              (in_k),
    .in_k_vld          (in_k_vld),
    .in_fixed_data     (in_fixed_data),
    .in_fixed_data_vld (in_fixed_data_vld),
    .scale_pos         (scale_pos),
    .vector_done       (vector_done),
    .sum_float         (out_sum_float),
    .sum_float_vld     (out_sum_float_vld)
  );

  vector_buffer u_buf (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_fixed_data     (in_fixed_data),
    .in_fixed_data_vld (in_fixed_data_vld),
    .in_gamma          (in_gamma),
    .in_gamma_vld      (in_gamma_vld),
    .scale_pos         (scale_pos),
    .rd_en             (rd_en),
    .vector_done       (vector_done),
    .x_row             (x_row),
    .gamma_row         (gamma_row),
    .row_vld           (row_vld)
  );

  // One multiplier per lane, x times gamma
  for (genvar i = 0; i < `BUS_NUM; i++) begin : g_mult
    bf16_mult u_mult (
      .clk    (clk),
      .rst_n  (rst_n),
      .a      (x_row[i]),
      .b      (gamma_row[i]),
      .in_vld (row_vld[i]),
      .z      (out_data[i]),
      .z_vld  (out_data_vld[i])
    );
  end

  assign out_data_last = vector_done;

endmodule

// ==== verif/tb_clk_gen.sv ====
// Testbench clock source
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

endmodule

// ==== verif/rms_norm_tb.sv ====
// RMS norm front end testbench
`timescale 1ns/1ns
`include "rms_norm_defines.svh"

module rms_norm_tb import rms_norm_pkg::*; ();

  localparam int ROW_BITS   = `BUS_NUM * `FLOAT_WIDTH;
  localparam int DATA_BITS  = `BUS_NUM * `DATA_WIDTH;
  localparam int WAIT_LIMIT = 40;

  logic                                  clk;
  logic                                  rst_n;
  logic [`DATA_NUM_WIDTH-1:0]            in_data_num;
  logic                                  in_data_num_vld;
  logic [`DATA_NUM_WIDTH-1:0]            in_k;
  logic                                  in_k_vld;
  logic signed [`SCALE_POS_WIDTH-1:0]    in_scale_pos;
  logic                                  in_scale_pos_vld;
  logic [`BUS_NUM-1:0][`DATA_WIDTH-1:0]  in_fixed_data;
  lane_vld_t                             in_fixed_data_vld;
  bf16_t [`BUS_NUM-1:0]                  in_gamma;
  lane_vld_t                             in_gamma_vld;
  bf16_t                                 out_sum_float;
  logic                                  out_sum_float_vld;
  bf16_t [`BUS_NUM-1:0]                  out_data;
  lane_vld_t                             out_data_vld;
  logic                                  out_data_last;

  int                                    fd;
  int                                    code;
  int                                    check_cnt;
  int                                    cfg_num;
  int                                    cfg_k;
  int                                    cfg_scale;
  int unsigned                           rnd_init;
  int unsigned                           gap;
  logic [63:0]                           tag;
  logic [8*256-1:0]                      skip_line;
  logic [DATA_BITS-1:0]                  data_word;
  logic [ROW_BITS-1:0]                   gamma_word;
  logic [ROW_BITS-1:0]                   exp_word;
  logic [`BUS_NUM-1:0]                   exp_vld;
  logic                                  exp_last;

  tb_clk_gen #(.PERIOD(20)) u_clk_gen (.clk(clk));

  rms_norm_top DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_data_num       (in_data_num),
    .in_data_num_vld   (in_data_num_vld),
    .in_k              (in_k),
    .in_k_vld          (in_k_vld),
    .in_scale_pos      (in_scale_pos),
    .in_scale_pos_vld  (in_scale_pos_vld),
    .in_fixed_data     (in_fixed_data),
    .in_fixed_data_vld (in_fixed_data_vld),
    .in_gamma          (in_gamma),
    .in_gamma_vld      (in_gamma_vld),
    .out_sum_float     (out_sum_float),
    .out_sum_float_vld (out_sum_float_vld),
    .out_data          (out_data),
    .out_data_vld      (out_data_vld),
    .out_data_last     (out_data_last)
  );

  // ----------------------------------------------------------
  // Checking and abort
  // ----------------------------------------------------------
  task automatic check_equal(input string what, input logic [ROW_BITS-1:0] actual,
                             input logic [ROW_BITS-1:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      $display("Error: time %0t ns, %s is %h, expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s at time %0t ns", why, $time);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // Only lanes with a valid strobe carry a defined product
  function automatic logic [ROW_BITS-1:0] lane_mask(input logic [`BUS_NUM-1:0] vld);
    logic [ROW_BITS-1:0] mask;
    mask = '0;
    for (int i = 0; i < `BUS_NUM; i++) begin
      if (vld[i]) begin
        mask[i*`FLOAT_WIDTH +: `FLOAT_WIDTH] = '1;
      end
    end
    return mask;
  endfunction

  // ----------------------------------------------------------
  // Stimulus, applied on the falling edge
  // ----------------------------------------------------------
  task automatic clear_inputs();
    in_data_num_vld   = 1'b0;
    in_k_vld          = 1'b0;
    in_scale_pos_vld  = 1'b0;
    in_fixed_data     = '0;
    in_fixed_data_vld = '0;
    in_gamma          = '0;
    in_gamma_vld      = '0;
  endtask

  task automatic drive_idle();
    @(negedge clk);
    clear_inputs();
  endtask

  task automatic load_config(input int num, input int k, input int scale);
    @(negedge clk);
    clear_inputs();
    in_data_num      = num[`DATA_NUM_WIDTH-1:0];
    in_data_num_vld  = 1'b1;
    in_k             = k[`DATA_NUM_WIDTH-1:0];
    in_k_vld         = 1'b1;
    in_scale_pos     = scale[`SCALE_POS_WIDTH-1:0];
    in_scale_pos_vld = 1'b1;
  endtask

  // Data and gamma of one row share the lane strobes
  task automatic drive_row(input logic [DATA_BITS-1:0] data, input logic [ROW_BITS-1:0] gamma,
                           input logic [`BUS_NUM-1:0] vld);
    @(negedge clk);
    clear_inputs();
    in_fixed_data     = data;
    in_fixed_data_vld = vld;
    in_gamma          = gamma;
    in_gamma_vld      = vld;
  endtask

  task automatic wait_sum();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (out_sum_float_vld !== 1'b1) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run("Timed out waiting for out_sum_float_vld");
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_row();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (out_data_vld === '0) begin
      cycles++;
      if (out_data_last !== 1'b0) begin
        stop_run("out_data_last went high without an output row");
      end else if (cycles > WAIT_LIMIT) begin
        stop_run("Timed out waiting for out_data_vld");
      end
      @(negedge clk);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_n        = 1'b0;
    in_data_num  = '0;
    in_k         = '0;
    in_scale_pos = '0;
    clear_inputs();
    check_cnt = 0;
    rnd_init  = $urandom(32'h76a9);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Nothing may come out before the first vector
    repeat (5) begin
      @(negedge clk);
      check_equal("out_sum_float_vld after reset", out_sum_float_vld, '0);
      check_equal("out_data_vld after reset", out_data_vld, '0);
      check_equal("out_data_last after reset", out_data_last, '0);
    end

    fd = $fopen("verif/rms_norm_trace.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open verif/rms_norm_trace.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(skip_line, fd);
      end else if (tag == "cfg") begin
        code = $fscanf(fd, "%d %d %d", cfg_num, cfg_k, cfg_scale);
        load_config(cfg_num, cfg_k, cfg_scale);
      end else if (tag == "in") begin
        code = $fscanf(fd, "%h %h %h", data_word, gamma_word, exp_vld);
        // Random idle cycles between rows
        gap = $urandom % 3;
        repeat (gap) drive_idle();
        drive_row(data_word, gamma_word, exp_vld);
      end else if (tag == "sum") begin
        code = $fscanf(fd, "%h", exp_word);
        drive_idle();
        wait_sum();
        check_equal("out_sum_float", out_sum_float, exp_word[`FLOAT_WIDTH-1:0]);
      end else if (tag == "out") begin
        code = $fscanf(fd, "%h %h %h", exp_vld, exp_last, exp_word);
        wait_row();
        check_equal("out_data_vld", out_data_vld, exp_vld);
        check_equal("out_data_last", out_data_last, exp_last);
        check_equal("out_data", out_data & lane_mask(exp_vld), exp_word & lane_mask(exp_vld));
      end else begin
        stop_run("Unknown line type in the trace file");
      end
    end
    $fclose(fd);

    // No stray outputs once the last vector is out
    repeat (4) begin
      @(negedge clk);
      check_equal("out_data_vld when idle", out_data_vld, '0);
      check_equal("out_sum_float_vld when idle", out_sum_float_vld, '0);
    end

    if (check_cnt == 0) begin
      stop_run("The trace file held no expected values");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== rms_norm_front.f ====
+incdir+src
src/rms_norm_pkg.sv
src/int_to_bf16.sv
src/bf16_mult.sv
src/square_sum_acc.sv
src/vector_buffer.sv
src/rms_norm_ctrl.sv
src/rms_norm_top.sv
verif/tb_clk_gen.sv
verif/rms_norm_tb.sv

// ==== verif/rms_norm_trace.txt ====
# cfg: data_num k scale_pos (decimal)  in: data lanes 3..0, gamma lanes 3..0, lane valids
# sum: expected bf16 sum  out: lane valids, last flag, expected bf16 lanes 3..0 (all hex)
# Vector 1 two full rows with K equal to data_num
cfg 8 8 2
in 0108FD04 40403F003FC04000 F
in 07FA0502 3F803F40BF803FA0 F
sum 424C
out F 0 3F403F80BF904000
out F 1 3FE0BF90BFA03F20
# Vector 2 K ends inside a partial last row
cfg 7 5 0
in 04FF0203 BF0040003F803F00 F
in 00FE060A 0000BFA03FC03E80 7
sum 4302
out F 0 C000C00040003FC0
out 7 1 0000402041104020
# Vector 3 all zero data
cfg 4 4 0
in 00000000 3F804000BF803FC0 F
sum 0000
out F 1 0000000000000000
# Vector 4 negative inputs with a negative scale position
cfg 3 3 -1
in 00FF03FB 00003F00C0003F80 7
sum 428C
out 7 1 0000BF80C140C120
